// ==== dram_pkg.sv ====
/*
  dram channel model shared definitions
  word and address field widths and the channel address layout
*/
package dram_pkg;

  localparam int dram_data_w = 32;
  localparam int dram_mask_w = dram_data_w / 8;

  // address fields, row in the upper bits
  localparam int dram_off_w  = 2;
  localparam int dram_col_w  = 6;
  localparam int dram_bank_w = 2;
  localparam int dram_row_w  = 6;

  localparam int dram_addr_w = dram_row_w + dram_bank_w + dram_col_w + dram_off_w;
  localparam int dram_words  = 2 ** (dram_addr_w - dram_off_w);

  // latency and due cycle counters
  localparam int dram_lat_w = 8;

  // channel byte address, flat or split into dram fields
  typedef union packed {
    logic [dram_addr_w-1:0] flat;
    struct packed {
      logic [dram_row_w-1:0]  row;
      logic [dram_bank_w-1:0] bank;
      logic [dram_col_w-1:0]  col;
      logic [dram_off_w-1:0]  off;
    } fields;
  } dram_addr_u;

endpackage

// ==== dram_row_tracker.sv ====
/*
  dram row tracker
  keeps one open row per bank and prices each request as hit, empty or conflict
*/
`timescale 1ns/1ps

module dram_row_tracker #(
  parameter int t_cl_p  = 3,
  parameter int t_rcd_p = 4,
  parameter int t_rp_p  = 5
) (
  input  logic                            clk_i,
  input  logic                            mask_i,
  input  logic                            req_i,
  input  dram_pkg::dram_addr_u            addr_i,
  output logic [dram_pkg::dram_lat_w-1:0] lat_o
);

  import dram_pkg::*;

  localparam int num_banks_lp = 2 ** dram_bank_w;

  logic [num_banks_lp-1:0] open_v;
  logic [dram_row_w-1:0]   open_row [num_banks_lp];

  // latency for the bank and row being addressed
  always_comb begin
    if (!open_v[addr_i.fields.bank]) begin
      lat_o = dram_lat_w'(t_rcd_p + t_cl_p);
    end else if (open_row[addr_i.fields.bank] == addr_i.fields.row) begin
      lat_o = dram_lat_w'(t_cl_p);
    end else begin
      // precharge, then activate the new row
      lat_o = dram_lat_w'(t_rp_p + t_rcd_p + t_cl_p);
    end
  end

  // all banks closed out of reset
  always_ff @(posedge clk_i or negedge mask_i) begin
    if (!mask_i) begin
      open_v <= '0;
    end else if (req_i) begin
      open_v[addr_i.fields.bank] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      open_row[addr_i.fields.bank] <= addr_i.fields.row;
    end
  end

endmodule

// ==== dram_done_queue.sv ====
/*
  dram completion queue
  holds accepted requests in order with absolute due cycles, retires the head when due
*/
`timescale 1ns/1ps

module dram_done_queue #(
  parameter int depth_p = 4
) (
  input  logic                            clk_i,
  input  logic                            mask_i,
  input  logic                            push_i,
  input  dram_pkg::dram_addr_u            addr_i,
  input  logic                            write_i,
  input  logic [dram_pkg::dram_lat_w-1:0] lat_i,
  output logic                            full_o,
  output logic                            done_o,
  output dram_pkg::dram_addr_u            done_addr_o,
  output logic                            done_write_o
);

  import dram_pkg::*;

  localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_w_lp = $clog2(depth_p + 1);

  logic [dram_lat_w-1:0] due_q   [depth_p];
  dram_addr_u            addr_q  [depth_p];
  logic                  write_q [depth_p];

  logic [ptr_w_lp-1:0]   wr_ptr;
  logic [ptr_w_lp-1:0]   rd_ptr;
  logic [cnt_w_lp-1:0]   count;
  logic [dram_lat_w-1:0] now;
  logic [dram_lat_w-1:0] last_due;
  logic [dram_lat_w-1:0] ahead;
  logic [dram_lat_w-1:0] offset;
  logic [dram_lat_w-1:0] due;

  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] p);
    if (p == ptr_w_lp'(depth_p - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // cycles until the youngest entry falls due
  assign ahead = last_due - now;

  // later of now + lat and one past the previous entry
  always_comb begin
    offset = lat_i;
    if ((count != '0) && ((ahead + dram_lat_w'(1)) > lat_i)) begin
      offset = ahead + dram_lat_w'(1);
    end
  end

  assign due = now + offset;

  assign full_o       = (count == cnt_w_lp'(depth_p));
  assign done_o       = (count != '0) && (due_q[rd_ptr] == now);
  assign done_addr_o  = addr_q[rd_ptr];
  assign done_write_o = write_q[rd_ptr];

  always_ff @(posedge clk_i or negedge mask_i) begin
    if (!mask_i) begin
      now    <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // free running, wraps with the due cycles
      now <= now + 1'b1;
      if (push_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (done_o) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push_i, done_o})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      due_q[wr_ptr]   <= due;
      addr_q[wr_ptr]  <= addr_i;
      write_q[wr_ptr] <= write_i;
      last_due        <= due;
    end
  end

endmodule

// ==== dram_byte_mem.sv ====
/*
  dram channel storage
  word array with byte enables on write and a registered read port
*/
`timescale 1ns/1ps

module dram_byte_mem (
  input  logic                                                  clk_i,
  input  logic                                                  w_v_i,
  input  logic [dram_pkg::dram_addr_w-dram_pkg::dram_off_w-1:0] w_addr_i,
  input  logic [dram_pkg::dram_data_w-1:0]                      w_data_i,
  input  logic [dram_pkg::dram_mask_w-1:0]                      w_mask_i,
  input  logic                                                  r_v_i,
  input  logic [dram_pkg::dram_addr_w-dram_pkg::dram_off_w-1:0] r_addr_i,
  output logic [dram_pkg::dram_data_w-1:0]                      r_data_o
);

  import dram_pkg::*;

  logic [dram_data_w-1:0] mem [dram_words];

  // model starts from zeroed memory
  initial begin
    for (int i = 0; i < dram_words; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < dram_mask_w; b++) begin
      if (w_v_i && w_mask_i[b]) begin
        mem[w_addr_i][8*b +: 8] <= w_data_i[8*b +: 8];
      end
    end
  end

  // read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (r_v_i) begin
      r_data_o <= mem[r_addr_i];
    end
  end

endmodule

// ==== dram_channel.sv ====
/*
  dram channel
  accepts requests, writes at acceptance and returns reads and write completions in order
*/
`timescale 1ns/1ps

module dram_channel #(
  parameter int t_cl_p  = 3,
  parameter int t_rcd_p = 4,
  parameter int t_rp_p  = 5,
  parameter int depth_p = 4
) (
  input  logic                             clk_i,
  input  logic                             mask_i,
  input  logic                             v_i,
  input  logic                             write_not_read_i,
  input  dram_pkg::dram_addr_u             addr_i,
  input  logic [dram_pkg::dram_data_w-1:0] data_i,
  input  logic [dram_pkg::dram_mask_w-1:0] wmask_i,
  output logic                             yumi_o,
  output logic                             data_v_o,
  output logic [dram_pkg::dram_data_w-1:0] data_o,
  output dram_pkg::dram_addr_u             read_done_addr_o,
  output logic                             write_done_o,
  output dram_pkg::dram_addr_u             write_done_addr_o
);

  import dram_pkg::*;

  logic                  full;
  logic [dram_lat_w-1:0] lat;
  logic                  done;
  logic                  done_write;
  dram_addr_u            done_addr;
  logic                  rd_pend;
  dram_addr_u            rd_addr;

  // accept whenever the completion queue has room
  assign yumi_o = v_i & ~full;

  dram_row_tracker #(
    .t_cl_p (t_cl_p),
    .t_rcd_p(t_rcd_p),
    .t_rp_p (t_rp_p)
  ) tracker_i (
    .clk_i (clk_i),
    .mask_i(mask_i),
    .req_i (yumi_o),
    .addr_i(addr_i),
    .lat_o (lat)
  );

  dram_done_queue #(
    .depth_p(depth_p)
  ) queue_i (
    .clk_i       (clk_i),
    .mask_i      (mask_i),
    .push_i      (yumi_o),
    .addr_i      (addr_i),
    .write_i     (write_not_read_i),
    .lat_i       (lat),
    .full_o      (full),
    .done_o      (done),
    .done_addr_o (done_addr),
    .done_write_o(done_write)
  );

  // writes land in the array at acceptance
  dram_byte_mem mem_i (
    .clk_i   (clk_i),
    .w_v_i   (yumi_o & write_not_read_i),
    .w_addr_i(addr_i.flat[dram_addr_w-1:dram_off_w]),
    .w_data_i(data_i),
    .w_mask_i(wmask_i),
    .r_v_i   (rd_pend),
    .r_addr_i(rd_addr.flat[dram_addr_w-1:dram_off_w]),
    .r_data_o(data_o)
  );

  always_ff @(posedge clk_i or negedge mask_i) begin
    if (!mask_i) begin
      write_done_o <= 1'b0;
      rd_pend      <= 1'b0;
      data_v_o     <= 1'b0;
    end else begin
      write_done_o <= done & done_write;
      rd_pend      <= done & ~done_write;
      // valid lines up with the registered read data
      data_v_o     <= rd_pend;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done && done_write) begin
      write_done_addr_o <= done_addr;
    end
    if (done && !done_write) begin
      rd_addr <= done_addr;
    end
    if (rd_pend) begin
      read_done_addr_o <= rd_addr;
    end
  end

endmodule

// ==== dram_sim_top.sv ====
/*
  dram model top
  independent dram channels sharing one set of timing parameters
*/
`timescale 1ns/1ps

module dram_sim_top #(
  parameter int num_channels_p = 2,
  parameter int t_cl_p         = 3,
  parameter int t_rcd_p        = 4,
  parameter int t_rp_p         = 5,
  parameter int depth_p        = 4
) (
  input  logic                                                 clk_i,
  input  logic                                                 mask_i,
  input  logic [num_channels_p-1:0]                            v_i,
  input  logic [num_channels_p-1:0]                            write_not_read_i,
  input  logic [num_channels_p-1:0][dram_pkg::dram_addr_w-1:0] addr_i,
  input  logic [num_channels_p-1:0][dram_pkg::dram_data_w-1:0] data_i,
  input  logic [num_channels_p-1:0][dram_pkg::dram_mask_w-1:0] wmask_i,
  output logic [num_channels_p-1:0]                            yumi_o,
  output logic [num_channels_p-1:0]                            data_v_o,
  output logic [num_channels_p-1:0][dram_pkg::dram_data_w-1:0] data_o,
  output logic [num_channels_p-1:0][dram_pkg::dram_addr_w-1:0] read_done_addr_o,
  output logic [num_channels_p-1:0]                            write_done_o,
  output logic [num_channels_p-1:0][dram_pkg::dram_addr_w-1:0] write_done_addr_o
);

  for (genvar i = 0; i < num_channels_p; i++) begin : g_ch
    dram_channel #(
      .t_cl_p (t_cl_p),
      .t_rcd_p(t_rcd_p),
      .t_rp_p (t_rp_p),
      .depth_p(depth_p)
    ) channel_i (
      .clk_i            (clk_i),
      .mask_i           (mask_i),
      .v_i              (v_i[i]),
      .write_not_read_i (write_not_read_i[i]),
      .addr_i           (addr_i[i]),
      .data_i           (data_i[i]),
      .wmask_i          (wmask_i[i]),
      .yumi_o           (yumi_o[i]),
      .data_v_o         (data_v_o[i]),
      .data_o           (data_o[i]),
      .read_done_addr_o (read_done_addr_o[i]),
      .write_done_o     (write_done_o[i]),
      .write_done_addr_o(write_done_addr_o[i])
    );
  end

endmodule

// ==== tb_dram_sim.sv ====
/*
  dram_sim_top testbench
  directed traffic checked against a shadow memory and open-row table
*/
`timescale 1ns/1ps

module tb_dram_sim;

  import dram_pkg::*;

  localparam int nch_lp   = 2;
  localparam int t_cl_lp  = 3;
  localparam int t_rcd_lp = 4;
  localparam int t_rp_lp  = 5;
  localparam int depth_lp = 4;
  // latency 6, write/read 24, masks 18, back-pressure 8, concurrent 24
  localparam int n_req_lp = 80;
  localparam int limit_lp = 200 * n_req_lp + 1000;

  typedef struct {
    logic                   wr;
    logic [dram_addr_w-1:0] addr;
    logic [dram_data_w-1:0] data;
    int                     acc;
    int                     due;
  } exp_t;

  logic                               clk_i = 1'b0;
  logic                               mask_i;
  logic [nch_lp-1:0]                  v_i;
  logic [nch_lp-1:0]                  write_not_read_i;
  logic [nch_lp-1:0]                  yumi_o;
  logic [nch_lp-1:0]                  data_v_o;
  logic [nch_lp-1:0]                  write_done_o;
  logic [nch_lp-1:0][dram_addr_w-1:0] addr_i;
  logic [nch_lp-1:0][dram_addr_w-1:0] read_done_addr_o;
  logic [nch_lp-1:0][dram_addr_w-1:0] write_done_addr_o;
  logic [nch_lp-1:0][dram_data_w-1:0] data_i;
  logic [nch_lp-1:0][dram_data_w-1:0] data_o;
  logic [nch_lp-1:0][dram_mask_w-1:0] wmask_i;

  // shadow state and expected completions in acceptance order
  bit [dram_data_w-1:0] shadow [nch_lp][dram_words];
  bit                   open_v [nch_lp][2**dram_bank_w];
  bit [dram_row_w-1:0]  open_row [nch_lp][2**dram_bank_w];
  int                   last_due [nch_lp];
  bit                   full_seen [nch_lp];
  exp_t                 exp_q [nch_lp][$];
  int                   cyc = 0;
  int                   errors = 0;

  dram_sim_top #(
    .num_channels_p(nch_lp),
    .t_cl_p        (t_cl_lp),
    .t_rcd_p       (t_rcd_lp),
    .t_rp_p        (t_rp_lp),
    .depth_p       (depth_lp)
  ) dut_i (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic bad_value(input string name, input int ch, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
    $display("error t=%0t %s[%0d] expected %0h actual %0h", $time, name, ch, exp_v, act_v);
    errors++;
  endtask

  task automatic fault(input string msg);
    $display("t=%0t %s", $time, msg);
    errors++;
  endtask

  // drive one request and hold it until the channel takes it
  task automatic issue(input int ch, input logic wr, input logic [dram_addr_w-1:0] addr,
                       input logic [dram_mask_w-1:0] m);
    dram_addr_u             a;
    exp_t                   e;
    int                     lat;
    logic [dram_data_w-1:0] d;
    a.flat = addr;
    d = $urandom;
    v_i[ch]              <= 1'b1;
    write_not_read_i[ch] <= wr;
    addr_i[ch]           <= addr;
    data_i[ch]           <= d;
    wmask_i[ch]          <= m;
    do begin
      @(negedge clk_i);
    end while (!yumi_o[ch]);
    if (!open_v[ch][a.fields.bank]) lat = t_rcd_lp + t_cl_lp;
    else if (open_row[ch][a.fields.bank] == a.fields.row) lat = t_cl_lp;
    else lat = t_rp_lp + t_rcd_lp + t_cl_lp;
    open_v[ch][a.fields.bank]   = 1'b1;
    open_row[ch][a.fields.bank] = a.fields.row;
    // accepted on the coming edge
    e.acc = cyc + 1;
    // one past the previous due at the earliest
    e.due = (e.acc + lat > last_due[ch]) ? e.acc + lat : last_due[ch] + 1;
    last_due[ch] = e.due;
    for (int b = 0; b < dram_mask_w; b++) begin
      if (wr && m[b]) shadow[ch][addr[dram_addr_w-1:dram_off_w]][8*b +: 8] = d[8*b +: 8];
    end
    e.wr   = wr;
    e.addr = addr;
    e.data = shadow[ch][addr[dram_addr_w-1:dram_off_w]];
    exp_q[ch].push_back(e);
    @(posedge clk_i);
  endtask

  task automatic drain(input int ch);
    v_i[ch] <= 1'b0;
    while (exp_q[ch].size() != 0) @(posedge clk_i);
  endtask

  task automatic retire(input int ch, input logic wr);
    exp_t e;
    if (exp_q[ch].size() == 0) begin
      fault($sformatf("channel %0d gave a completion with nothing outstanding", ch));
      return;
    end
    e = exp_q[ch].pop_front();
    if (e.wr != wr) begin
      fault($sformatf("channel %0d completed a request out of acceptance order", ch));
    end else if (wr) begin
      if (write_done_addr_o[ch] != e.addr) begin
        bad_value("write_done_addr_o", ch, e.addr, write_done_addr_o[ch]);
      end
      if (cyc != e.due) bad_value("write_done_o cycle", ch, e.due, cyc);
    end else begin
      if (read_done_addr_o[ch] != e.addr) begin
        bad_value("read_done_addr_o", ch, e.addr, read_done_addr_o[ch]);
      end
      if (data_o[ch] != e.data) bad_value("data_o", ch, e.data, data_o[ch]);
      if (cyc != e.due + 1) bad_value("data_v_o cycle", ch, e.due + 1, cyc);
    end
  endtask

  task automatic watch_channel(input int ch);
    int occ;
    occ = 0;
    for (int i = 0; i < exp_q[ch].size(); i++) begin
      if (exp_q[ch][i].acc <= cyc && exp_q[ch][i].due > cyc) occ++;
    end
    if (v_i[ch] && occ == depth_lp && !yumi_o[ch]) full_seen[ch] = 1'b1;
    if (yumi_o[ch] != (v_i[ch] && occ < depth_lp)) begin
      bad_value("yumi_o", ch, v_i[ch] && occ < depth_lp, yumi_o[ch]);
    end
    // the read is older when a read return and a write done share a cycle
    if (data_v_o[ch]) retire(ch, 1'b0);
    if (write_done_o[ch]) retire(ch, 1'b1);
    if (exp_q[ch].size() != 0 && exp_q[ch][0].acc <= cyc && cyc > exp_q[ch][0].due + 1) begin
      fault($sformatf("channel %0d never answered the request to %0h", ch, exp_q[ch][0].addr));
      exp_q[ch].delete(0);
    end
  endtask

  always @(negedge clk_i) begin
    for (int ch = 0; ch < nch_lp; ch++) watch_channel(ch);
  end

  // empty bank then row hit then row conflict from an idle queue
  task automatic latency_classes(input int ch);
    issue(ch, 1'b0, {6'd5, 2'd2, 6'd1, 2'd0}, '0);
    drain(ch);
    issue(ch, 1'b0, {6'd5, 2'd2, 6'd7, 2'd0}, '0);
    drain(ch);
    issue(ch, 1'b0, {6'd9, 2'd2, 6'd1, 2'd0}, '0);
    drain(ch);
  endtask

  task automatic write_read(input int ch);
    logic [dram_addr_w-1:0] addrs [6];
    for (int i = 0; i < 6; i++) begin
      addrs[i] = dram_addr_w'($urandom);
      issue(ch, 1'b1, addrs[i], '1);
    end
    for (int i = 0; i < 6; i++) issue(ch, 1'b0, addrs[i], '0);
    drain(ch);
  endtask

  task automatic byte_masks(input int ch);
    logic [dram_addr_w-1:0] a;
    a = dram_addr_w'($urandom);
    issue(ch, 1'b1, a, '1);
    repeat (4) begin
      issue(ch, 1'b1, a, dram_mask_w'($urandom));
      issue(ch, 1'b0, a, '0);
      drain(ch);
    end
  endtask

  // conflicts in bank 1 keep entries in flight long enough to fill the queue
  task automatic back_pressure(input int ch);
    full_seen[ch] = 1'b0;
    for (int i = 0; i < 8; i++) begin
      issue(ch, i < 4, {(i % 2 != 0) ? 6'd41 : 6'd20, 2'd1, 6'(i % 4), 2'd0}, '1);
    end
    drain(ch);
    if (!full_seen[ch]) begin
      fault($sformatf("channel %0d never held off a request while its queue was full", ch));
    end
  endtask

  initial begin
    void'($urandom(32'hb889_4e31));
    mask_i           <= 1'b1;
    v_i              <= '0;
    write_not_read_i <= '0;
    addr_i           <= '0;
    data_i           <= '0;
    wmask_i          <= '0;
    @(posedge clk_i);
    mask_i <= 1'b0;
    repeat (10) @(posedge clk_i);
    mask_i <= 1'b1;
    @(posedge clk_i);
    for (int ch = 0; ch < nch_lp; ch++) latency_classes(ch);
    for (int ch = 0; ch < nch_lp; ch++) write_read(ch);
    for (int ch = 0; ch < nch_lp; ch++) byte_masks(ch);
    back_pressure(0);
    fork
      write_read(0);
      write_read(1);
    join
    repeat (4) @(posedge clk_i);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (limit_lp) @(posedge clk_i);
    $display("timeout: tests did not finish within %0d cycles", limit_lp);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
dram_pkg.sv
dram_row_tracker.sv
dram_done_queue.sv
dram_byte_mem.sv
dram_channel.sv
dram_sim_top.sv
tb_dram_sim.sv

// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tb_dram_sim
FLIST = tb.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
